// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Fixed frame format: start, data, even parity, stop
    localparam int DATA_BITS  = 8;
    localparam int STOP_BITS  = 2;
    localparam int FRAME_BITS = 1 + DATA_BITS + 1 + STOP_BITS;

    // Bit timing. One bit lasts OVERSAMPLE * CLKS_PER_TICK system clocks
    localparam int OVERSAMPLE    = 16;
    localparam int CLKS_PER_TICK = 4;   // Kept small to keep simulation short

    localparam int FIFO_DEPTH = 4;

    // Counter widths derived from the values above
    localparam int TICK_CNT_W = $clog2(CLKS_PER_TICK);
    localparam int OS_CNT_W   = $clog2(OVERSAMPLE);
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // One received word with its status flags
    typedef struct packed {
        uart_byte_t data;
        logic       break_err;   // Every sampled bit of the frame was low
        logic       parity_err;  // Parity bit differs from XOR of the data bits
        logic       frame_err;   // At least one stop bit was low
        logic       overrun;     // Some frame was dropped ahead of this one
    } rx_word_t;

endpackage

`default_nettype wire

// File: rtl/uart_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_fifo import uart_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     Clk,
    input  logic     Rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,    // Valid whenever empty is low
    output logic     empty,
    output logic     full
);

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign empty = (count == '0);
    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));

    // Push into a full FIFO or pop from an empty one is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];  // First word falls through

    always_ff @(posedge Clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither leaves the level alone
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic     Clk,
    input  logic     Rst,
    input  logic     rx,         // Serial line, idle high
    input  logic     fifo_full,
    output logic     rx_valid,   // One-cycle strobe with rx_frame
    output rx_word_t rx_frame,
    output logic     rts
);

    typedef enum logic [2:0] {
        st_idle,
        st_recv,
        st_output,
        st_calc,
        st_done
    } rx_state_t;

    rx_state_t state, next_state;

    logic                  start_det;  // Registered low level seen while idle
    logic [TICK_CNT_W-1:0] clk_cnt;    // System clocks within one oversampling tick
    logic [OS_CNT_W-1:0]   tick_cnt;   // Ticks within one bit
    logic                  tick;
    logic                  sample;     // Mid-point of the current bit
    logic [BIT_CNT_W-1:0]  bit_cnt;    // Bits still to be sampled
    logic [FRAME_BITS-1:0] rx_buf;     // Start bit ends up in the MSB

    // Start detector only armed in idle
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            start_det <= 1'b0;
        end else begin
            start_det <= (state == st_idle) && !rx;
        end
    end

    assign tick   = (clk_cnt == TICK_CNT_W'(CLKS_PER_TICK - 1));
    assign sample = tick && (tick_cnt == OS_CNT_W'(OVERSAMPLE / 2 - 1)) && (bit_cnt != '0);

    // Tick and mid-bit counters run only while receiving, so each frame starts aligned
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            clk_cnt  <= '0;
            tick_cnt <= '0;
            bit_cnt  <= BIT_CNT_W'(FRAME_BITS);
        end else if (state != st_recv) begin
            clk_cnt  <= '0;
            tick_cnt <= '0;
            bit_cnt  <= BIT_CNT_W'(FRAME_BITS);
        end else begin
            clk_cnt <= tick ? '0 : clk_cnt + 1'b1;
            if (tick) begin
                // Wrap explicitly, OVERSAMPLE need not be a power of two
                tick_cnt <= (tick_cnt == OS_CNT_W'(OVERSAMPLE - 1)) ? '0 : tick_cnt + 1'b1;
            end
            if (sample) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // Shift buffer takes the line at each mid-point, first bit lands highest
    always_ff @(posedge Clk) begin
        if (sample) begin
            rx_buf <= {rx_buf[FRAME_BITS-2:0], rx};
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:   if (start_det) next_state = st_recv;
            st_recv:   if (bit_cnt == '0) next_state = st_output;  // All FRAME_BITS latched
            st_output: next_state = st_calc;    // Data copied out this cycle
            st_calc:   next_state = st_done;    // Flags computed this cycle
            st_done:   next_state = st_idle;    // Strobe, then back to hunting
            default:   next_state = st_idle;
        endcase
    end

    // Data goes out one clock before the flags, both settle before the strobe
    always_ff @(posedge Clk) begin
        if (state == st_output) begin
            rx_frame.data    <= rx_buf[FRAME_BITS-2 -: DATA_BITS];
            rx_frame.overrun <= 1'b0;   // Filled in by the top from its drop flag
        end
        if (state == st_calc) begin
            rx_frame.break_err  <= (rx_buf == '0);
            rx_frame.parity_err <= (rx_buf[STOP_BITS] != ^rx_frame.data);  // Even parity
            rx_frame.frame_err  <= (rx_buf[STOP_BITS-1:0] != '1);
        end
    end

    assign rx_valid = (state == st_done);

    // Ready to send only when idle and the receive FIFO can take a word
    assign rts = (state == st_idle) && !fifo_full;

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic       Clk,
    input  logic       Rst,
    input  logic       fifo_empty,
    input  uart_byte_t fifo_data,   // Head of the transmit FIFO
    input  logic       cts,
    output logic       pop,         // One-cycle strobe when a frame starts
    output logic       tx           // Serial line, idle high
);

    logic                  busy;
    logic [FRAME_BITS-1:0] frame_sr;   // Bit on the line is the MSB
    logic [TICK_CNT_W-1:0] clk_cnt;
    logic [OS_CNT_W-1:0]   tick_cnt;
    logic [BIT_CNT_W-1:0]  bits_left;
    logic                  tick;
    logic                  bit_end;    // Last clock of the current bit period

    // cts is looked at only here, so a drop mid-frame waits for the frame to end
    assign pop = !busy && !fifo_empty && cts;

    assign tick    = (clk_cnt == TICK_CNT_W'(CLKS_PER_TICK - 1));
    assign bit_end = tick && (tick_cnt == OS_CNT_W'(OVERSAMPLE - 1));

    assign tx = frame_sr[FRAME_BITS-1];

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            busy      <= 1'b0;
            frame_sr  <= '1;    // Line idles high
            clk_cnt   <= '0;
            tick_cnt  <= '0;
            bits_left <= '0;
        end else if (pop) begin
            // Start bit goes on the line at this edge
            busy      <= 1'b1;
            frame_sr  <= {1'b0, fifo_data, ^fifo_data, {STOP_BITS{1'b1}}};
            clk_cnt   <= '0;
            tick_cnt  <= '0;
            bits_left <= BIT_CNT_W'(FRAME_BITS);
        end else if (busy) begin
            clk_cnt <= tick ? '0 : clk_cnt + 1'b1;
            if (tick) begin
                tick_cnt <= (tick_cnt == OS_CNT_W'(OVERSAMPLE - 1)) ? '0 : tick_cnt + 1'b1;
            end
            if (bit_end) begin
                frame_sr  <= {frame_sr[FRAME_BITS-2:0], 1'b1};  // Ones fill in behind
                bits_left <= bits_left - 1'b1;
                if (bits_left == BIT_CNT_W'(1)) begin
                    busy <= 1'b0;   // Last stop bit done, next frame may start next cycle
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top import uart_pkg::*; (
    input  logic       Clk,
    input  logic       Rst,
    input  logic       rx,
    input  logic       cts,
    input  logic       tx_wr,      // Ignored while tx_full is high
    input  uart_byte_t tx_data,
    input  logic       rx_rd,      // Ignored while rx_empty is high
    output logic       tx,
    output logic       rts,
    output logic       tx_full,
    output rx_word_t   rx_word,
    output logic       rx_empty
);

    logic       rx_valid;
    rx_word_t   rx_frame;
    logic       rx_full;
    logic       rx_push;
    rx_word_t   rx_push_word;
    logic       drop_flag;     // Sticky until the next word gets in
    logic       tx_pop;
    logic       tx_empty;
    uart_byte_t tx_head;

    // Frames are never held back, a full FIFO just loses them
    assign rx_push = rx_valid && !rx_full;

    always_comb begin
        rx_push_word         = rx_frame;
        rx_push_word.overrun = drop_flag;   // Tag the first word after a loss
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            drop_flag <= 1'b0;
        end else if (rx_valid && rx_full) begin
            drop_flag <= 1'b1;
        end else if (rx_push) begin
            drop_flag <= 1'b0;
        end
    end

    uart_rx u_rx (
        .Clk(Clk), .Rst(Rst), .rx(rx), .fifo_full(rx_full),
        .rx_valid(rx_valid), .rx_frame(rx_frame), .rts(rts)
    );

    uart_fifo #(.payload_t(rx_word_t)) u_rx_fifo (
        .Clk(Clk), .Rst(Rst), .push(rx_push), .push_data(rx_push_word),
        .pop(rx_rd), .head(rx_word), .empty(rx_empty), .full(rx_full)
    );

    uart_fifo #(.payload_t(uart_byte_t)) u_tx_fifo (
        .Clk(Clk), .Rst(Rst), .push(tx_wr), .push_data(tx_data),
        .pop(tx_pop), .head(tx_head), .empty(tx_empty), .full(tx_full)
    );

    uart_tx u_tx (
        .Clk(Clk), .Rst(Rst), .fifo_empty(tx_empty), .fifo_data(tx_head),
        .cts(cts), .pop(tx_pop), .tx(tx)
    );

endmodule

`default_nettype wire

// File: verif/uart_top_sva.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top_sva (
    input logic Clk,
    input logic Rst,
    input logic tx,
    input logic tx_busy,
    input logic tx_empty,
    input logic tx_full,
    input logic rx_valid,
    input logic rx_empty,
    input logic rx_full
);

    // Nothing queued and no frame in flight means the line rests high
    tx_idle_high: assert property (@(posedge Clk) disable iff (Rst)
        (tx_empty && !tx_busy) |-> tx)
        else $error("tx is low while the transmitter is idle with an empty FIFO");

    rx_valid_single: assert property (@(posedge Clk) disable iff (Rst)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held for more than one clock");

    // A full FIFO gives up at most one word per clock, so it is never empty on the next one
    rx_fifo_levels: assert property (@(posedge Clk) disable iff (Rst)
        rx_full |=> !rx_empty)
        else $error("receive FIFO went from full to empty in one clock");

    tx_fifo_levels: assert property (@(posedge Clk) disable iff (Rst)
        tx_full |=> !tx_empty)
        else $error("transmit FIFO went from full to empty in one clock");

endmodule

bind uart_top uart_top_sva u_sva (
    .Clk(Clk), .Rst(Rst), .tx(tx), .tx_busy(u_tx.busy), .tx_empty(tx_empty),
    .tx_full(tx_full), .rx_valid(rx_valid), .rx_empty(rx_empty), .rx_full(rx_full)
);

`default_nettype wire

// File: verif/tb_uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_top import uart_pkg::*; ();

    localparam int BIT_CLKS   = OVERSAMPLE * CLKS_PER_TICK;
    localparam int WAIT_LIMIT = 4 * FRAME_BITS * BIT_CLKS;   // Clocks before a wait gives up

    logic       Clk;
    logic       Rst;
    logic       rx;
    logic       cts;
    logic       tx_wr;
    uart_byte_t tx_data;
    logic       rx_rd;
    logic       tx;
    logic       rts;
    logic       tx_full;
    rx_word_t   rx_word;
    logic       rx_empty;

    rx_word_t    exp_q[$];        // Words the receive FIFO should hand out, oldest first
    logic [31:0] lcg_state;
    int          err_cnt  = 0;
    int          test_cnt = 0;
    int          fail_cnt = 0;
    int          err_mark = 0;    // Error count when the current test began

    uart_top u_dut (.*);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    function automatic uart_byte_t lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];   // Upper bits of an LCG are the better random ones
    endfunction

    // Decode a frame by the line rules, bits[FRAME_BITS-1] is the start bit
    function automatic rx_word_t expected_rx_word(logic [FRAME_BITS-1:0] bits);
        rx_word_t w;
        logic     par;
        w   = '0;
        par = 1'b0;
        for (int i = 0; i < DATA_BITS; i++) begin
            w.data[DATA_BITS-1-i] = bits[FRAME_BITS-2-i];   // MSB follows the start bit
            par = par ^ bits[FRAME_BITS-2-i];
        end
        w.break_err  = (bits == '0);
        w.parity_err = (bits[STOP_BITS] != par);   // Parity bit sits just after the data
        for (int i = 0; i < STOP_BITS; i++) begin
            if (!bits[i]) begin
                w.frame_err = 1'b1;
            end
        end
        return w;
    endfunction

    task automatic check_rx_word(input string name, input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            // Flags print as break, parity, frame, overrun
            $display("ERROR: at %0d ns %s got %02h/%04b expected %02h/%04b", $time, name,
                     got.data, got[3:0], exp.data, exp[3:0]);
            err_cnt++;
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("ERROR: at %0d ns %s got %02h expected %02h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR: at %0d ns %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // Shift one frame onto rx in line order, each bit held for one full bit time
    task automatic drive_frame(input uart_byte_t d, input bit bad_parity, input bit bad_stop,
                               input bit hold_low, output logic [FRAME_BITS-1:0] bits);
        bits = {1'b0, d, ^d ^ bad_parity, {STOP_BITS{1'b1}}};
        if (bad_stop) begin
            bits[STOP_BITS-1] = 1'b0;   // First stop bit low, line still ends high
        end
        if (hold_low) begin
            bits = '0;
        end
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            @(posedge Clk);
            rx <= bits[i];
            if (hold_low && i == 0) begin
                // Release just after the last mid-bit sample, before the receiver hunts again
                repeat (BIT_CLKS / 2 + 4) @(posedge Clk);
                rx <= 1'b1;
                repeat (BIT_CLKS / 2 - 5) @(posedge Clk);
            end else begin
                repeat (BIT_CLKS - 1) @(posedge Clk);
            end
        end
    endtask

    // Wait for a word at the FIFO head, then pop it with one rx_rd strobe
    task automatic read_word();
        int n;
        n = 0;
        @(negedge Clk);
        while (rx_empty && n < WAIT_LIMIT) begin
            @(negedge Clk);
            n++;
        end
        if (rx_empty) begin
            $display("ERROR: at %0d ns no word reached the receive FIFO", $time);
            err_cnt++;
        end
        @(posedge Clk);
        rx_rd <= 1'b1;
        @(posedge Clk);
        rx_rd <= 1'b0;
    endtask

    task automatic write_byte(input uart_byte_t d);
        @(posedge Clk);
        tx_wr   <= 1'b1;
        tx_data <= d;
        @(posedge Clk);
        tx_wr <= 1'b0;
    endtask

    // Find the start bit on tx, then sample each bit at its mid-point
    task automatic capture_tx(input uart_byte_t exp);
        logic [FRAME_BITS-1:0] bits;
        rx_word_t              w;
        int                    n;
        n = 0;
        @(negedge Clk);
        while (tx && n < WAIT_LIMIT) begin
            @(negedge Clk);
            n++;
        end
        if (tx) begin
            $display("ERROR: at %0d ns no start bit appeared on tx", $time);
            err_cnt++;
        end else begin
            repeat (BIT_CLKS / 2) @(negedge Clk);
            for (int i = FRAME_BITS - 1; i >= 0; i--) begin
                bits[i] = tx;
                if (i > 0) begin
                    repeat (BIT_CLKS) @(negedge Clk);
                end
            end
            w = expected_rx_word(bits);   // Same line rules decode the sent frame
            check_byte("tx data", w.data, exp);
            if (bits[FRAME_BITS-1] || w.parity_err || w.frame_err) begin
                $display("ERROR: at %0d ns tx frame %03h has a bad start, parity or stop bit",
                         $time, bits);
                err_cnt++;
            end
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == err_mark) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // Every word popped from the receive FIFO is matched against the oldest expectation
    always @(negedge Clk) begin
        if (!Rst && rx_rd && !rx_empty) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: at %0d ns a word was read with nothing expected", $time);
                err_cnt++;
            end else begin
                check_rx_word("rx_word", rx_word, exp_q.pop_front());
            end
        end
    end

    initial begin
        logic [FRAME_BITS-1:0] bits;
        uart_byte_t            tx_bytes [FIFO_DEPTH];
        rx_word_t              w;
        logic                  held;
        Rst       = 1'b1;
        rx        = 1'b1;
        cts       = 1'b1;
        tx_wr     = 1'b0;
        tx_data   = '0;
        rx_rd     = 1'b0;
        lcg_state = 32'd20;
        repeat (2) @(posedge Clk);
        Rst <= 1'b0;

        for (int i = 0; i < 8; i++) begin
            drive_frame(lcg_byte(), 1'b0, 1'b0, 1'b0, bits);
            exp_q.push_back(expected_rx_word(bits));
            read_word();
            @(negedge Clk);
            check_level("rts", rts, 1'b1);   // Idle with room between frames
        end
        end_test("clean frames");

        drive_frame(lcg_byte(), 1'b1, 1'b0, 1'b0, bits);
        exp_q.push_back(expected_rx_word(bits));
        read_word();
        end_test("parity error");

        drive_frame(lcg_byte(), 1'b0, 1'b1, 1'b0, bits);
        exp_q.push_back(expected_rx_word(bits));
        read_word();
        drive_frame('0, 1'b0, 1'b0, 1'b1, bits);   // Break, zero data has zero parity
        exp_q.push_back(expected_rx_word(bits));
        read_word();
        end_test("stop bit and break errors");

        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            drive_frame(lcg_byte(), 1'b0, 1'b0, 1'b0, bits);
            if (i < FIFO_DEPTH) begin
                exp_q.push_back(expected_rx_word(bits));   // The extra frame finds it full
            end
        end
        @(negedge Clk);
        check_level("rts", rts, 1'b0);
        repeat (FIFO_DEPTH) read_word();
        drive_frame(lcg_byte(), 1'b0, 1'b0, 1'b0, bits);
        w         = expected_rx_word(bits);
        w.overrun = 1'b1;   // First word after the lost frame
        exp_q.push_back(w);
        read_word();
        end_test("overrun");

        foreach (tx_bytes[i]) begin
            tx_bytes[i] = lcg_byte();
        end
        fork
            for (int i = 0; i < 4; i++) begin
                write_byte(tx_bytes[i]);
            end
            for (int i = 0; i < 4; i++) begin
                capture_tx(tx_bytes[i]);
            end
        join
        end_test("transmit");

        @(posedge Clk);
        cts <= 1'b0;
        foreach (tx_bytes[i]) begin
            tx_bytes[i] = lcg_byte();
            write_byte(tx_bytes[i]);
        end
        @(negedge Clk);
        check_level("tx_full", tx_full, 1'b1);   // Every byte is still waiting in the FIFO
        held = 1'b1;
        repeat (200 * BIT_CLKS) begin
            @(negedge Clk);
            held = held & tx;
        end
        check_level("tx with cts low", held, 1'b1);
        @(posedge Clk);
        cts <= 1'b1;
        foreach (tx_bytes[i]) begin
            capture_tx(tx_bytes[i]);
        end
        end_test("clear to send");

        check_level("rx_empty", rx_empty, 1'b1);
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d expected words were never read", exp_q.size());
            err_cnt++;
        end
        $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_top.sv
verif/uart_top_sva.sv
verif/tb_uart_top.sv

// File: run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_uart_top -f build.f \
    && ./obj_dir/Vtb_uart_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qsx "PASS: all tests" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
